// File: Makefile
TOP = tb_uart_alu
SIM = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f build.f

run: compile
	@out=$$(./$(SIM) +verilator+error+limit+10); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: build.f
verilog/uart_pkg.sv
verilog/alu_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_rx.sv
verilog/cmd_collector.sv
verilog/skid_buffer.sv
verilog/alu_exec.sv
verilog/uart_tx.sv
verilog/uart_alu_top.sv
verif/uart_alu_assertions.sv
verif/tb_uart_alu.sv

// File: verif/tb_uart_alu.sv
module tb_uart_alu
    import uart_pkg::*;
    import alu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYCLES   = (1 + WORD_BITS + STOP_BITS) * BIT_CYCLES;
    localparam int SENT_FRAMES    = 34;     // 11 commands of 3 frames plus 1 bad frame
    localparam int TIMEOUT_CYCLES = (SENT_FRAMES + 8) * FRAME_CYCLES;

    logic i_rate;
    logic i_reset;
    logic i_rx;
    logic o_tx;

    logic [7:0]  exp_q [$];
    logic [7:0]  op_list [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                 OP_NOR, OP_SRA, OP_SRL, 8'h3F};
    logic [15:0] lfsr_state;
    int          cycle_cnt = 0;
    int          n_sent = 0;
    int          n_got = 0;
    logic        decoding = 1'b0;

    uart_alu_top dut (
        .i_rate  (i_rate),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_tx    (o_tx)
    );

    always #5 i_rate = ~i_rate;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic draw_byte(output logic [7:0] v);
        for (int i = 0; i < 8; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Expected byte from the opcode table
    function automatic logic [7:0] predict_result(input logic [7:0] a, input logic [7:0] b,
                                                  input logic [7:0] op);
        logic [7:0] r;
        int sh;
        sh = int'(b);
        r = 8'h00;
        case (op)
            OP_ADD: r = 8'((int'(a) + int'(b)) % 256);
            OP_SUB: r = 8'((int'(a) + 256 - int'(b)) % 256);
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_XOR: r = a ^ b;
            OP_NOR: r = ~(a | b);
            OP_SRA, OP_SRL: begin
                for (int k = 0; k < 8; k++) begin
                    if (k + sh < 8) r[k] = a[k + sh];
                    else r[k] = (op == OP_SRA) ? a[7] : 1'b0;
                end
            end
            default: r = 8'h00;
        endcase
        return r;
    endfunction

    task automatic hold_line(input logic level, input int cycles);
        i_rx <= level;
        repeat (cycles) @(posedge i_rate);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_ok);
        hold_line(1'b0, BIT_CYCLES);
        for (int i = 0; i < WORD_BITS; i++) begin
            hold_line(data[i], BIT_CYCLES);
        end
        hold_line(stop_ok, BIT_CYCLES);     // Low here drops the frame
        hold_line(1'b1, BIT_CYCLES);
    endtask

    task automatic send_cmd(input logic [7:0] a, input logic [7:0] b, input logic [7:0] op);
        exp_q.push_back(predict_result(a, b, op));
        n_sent++;
        send_frame(a, 1'b1);
        send_frame(b, 1'b1);
        send_frame(op, 1'b1);
    endtask

    task automatic compare_byte(input logic [7:0] got);
        logic [7:0] want;
        if (exp_q.size() == 0) begin
            abort_run($sformatf("unexpected byte %02h on o_tx with no command pending", got));
        end else begin
            want = exp_q.pop_front();
            n_got++;
            if (got !== want) begin
                abort_run($sformatf("FAILED at %0t: result expected %02h, got %02h",
                                    $time, want, got));
            end
        end
    endtask

    initial begin
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] junk;
        i_rate = 1'b0;
        i_reset = 1'b0;
        i_rx = 1'b1;
        lfsr_state = 16'd27;
        repeat (2) @(posedge i_rate);
        i_reset <= 1'b1;
        hold_line(1'b1, 4 * BIT_CYCLES);

        // All opcodes back to back with the last one outside the table
        foreach (op_list[k]) begin
            draw_byte(a);
            draw_byte(b);
            case (op_list[k])
                OP_SUB: begin
                    a = a & 8'h7F;          // a below b so it wraps
                    b = b | 8'h80;
                end
                OP_SRA: begin
                    a = a | 8'h80;          // Sign fill
                    b = b % 8'd7 + 8'd1;    // Shift of 1 to 7
                end
                OP_SRL: b = b & 8'h07;
                default: ;
            endcase
            send_cmd(a, b, op_list[k]);
        end

        // Bad first stop bit then one good command
        draw_byte(junk);
        send_frame(junk, 1'b0);
        hold_line(1'b1, 2 * BIT_CYCLES);
        draw_byte(a);
        draw_byte(b);
        send_cmd(a, b, OP_ADD);

        // Glitch well under half a bit
        hold_line(1'b0, BIT_CYCLES / 5);
        hold_line(1'b1, 2 * BIT_CYCLES);
        draw_byte(a);
        draw_byte(b);
        send_cmd(a, b, OP_XOR);

        while (exp_q.size() != 0) @(posedge i_rate);
        repeat (FRAME_CYCLES) @(posedge i_rate);
        if (decoding || n_got != n_sent) begin
            abort_run($sformatf("o_tx not idle at the end, %0d of %0d results seen",
                                n_got, n_sent));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // Rebuild bytes from o_tx sampled mid-bit on the falling clock
    initial begin
        logic       prev;
        logic [7:0] got;
        prev = 1'b1;
        forever begin
            @(negedge i_rate);
            if (prev && !o_tx) begin
                decoding = 1'b1;
                repeat (BIT_CYCLES / 2) @(negedge i_rate);
                if (o_tx) abort_run("start bit on o_tx went high before mid-bit");
                for (int i = 0; i < WORD_BITS; i++) begin
                    repeat (BIT_CYCLES) @(negedge i_rate);
                    got[i] = o_tx;
                end
                for (int s = 0; s < STOP_BITS; s++) begin
                    repeat (BIT_CYCLES) @(negedge i_rate);
                    if (!o_tx) abort_run("stop bit on o_tx was low");
                end
                compare_byte(got);
                decoding = 1'b0;
            end
            prev = o_tx;
        end
    end

    always @(posedge i_rate) begin
        cycle_cnt <= cycle_cnt + 1;
        if (dut.u_assert.any_fail) begin
            abort_run("an assertion in the bound checker failed");
        end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles with %0d results missing",
                                cycle_cnt, exp_q.size()));
        end
    end

endmodule

// File: verif/uart_alu_assertions.sv
module uart_alu_assertions
    import alu_pkg::*;
(
    input  logic        i_rate,
    input  logic        i_reset,
    input  logic        i_rx,
    input  logic        i_tx,
    input  logic        i_tick,
    input  logic        i_rx_valid,
    input  logic        i_col_valid,
    input  logic        i_col_ready,
    input  alu_cmd_t    i_col_cmd,
    input  logic        i_alu_valid,
    input  logic        i_alu_ready,
    input  alu_result_t i_alu_result,
    input  logic        i_res_valid,
    input  logic        i_res_ready,
    input  alu_result_t i_res_data
);

    timeunit 1ns;
    timeprecision 1ps;

    logic rx_fell;      // Serial input has been low since reset
    logic tx_used;      // Transmitter has taken a result
    logic fail_tx_idle = 1'b0;
    logic fail_rx_quiet = 1'b0;
    logic fail_tx_tick = 1'b0;
    logic fail_cmd_hold = 1'b0;
    logic fail_alu_hold = 1'b0;
    logic fail_res_hold = 1'b0;
    logic any_fail;

    assign any_fail = fail_tx_idle | fail_rx_quiet | fail_tx_tick
                      | fail_cmd_hold | fail_alu_hold | fail_res_hold;

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            rx_fell <= 1'b0;
            tx_used <= 1'b0;
        end else begin
            if (!i_rx) begin
                rx_fell <= 1'b1;
            end
            if (i_res_valid && i_res_ready) begin
                tx_used <= 1'b1;
            end
        end
    end

    a_tx_idle: assert property (@(posedge i_rate) disable iff (!i_reset)
        !tx_used |-> i_tx)
        else begin
            fail_tx_idle = 1'b1;
            $error("o_tx left idle before any result was accepted");
        end

    a_rx_quiet: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_rx_valid |-> rx_fell)
        else begin
            fail_rx_quiet = 1'b1;
            $error("receiver produced a byte while i_rx never went low");
        end

    // Line only moves in the cycle after a tick
    a_tx_tick: assert property (@(posedge i_rate) disable iff (!i_reset)
        $changed(i_tx) |-> $past(i_tick))
        else begin
            fail_tx_tick = 1'b1;
            $error("o_tx changed outside a tick cycle");
        end

    a_cmd_hold: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_col_valid && !i_col_ready |=> i_col_valid && $stable(i_col_cmd))
        else begin
            fail_cmd_hold = 1'b1;
            $error("command link dropped valid or payload before ready");
        end

    a_alu_hold: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_alu_valid && !i_alu_ready |=> i_alu_valid && $stable(i_alu_result))
        else begin
            fail_alu_hold = 1'b1;
            $error("result link dropped valid or payload before ready");
        end

    a_res_hold: assert property (@(posedge i_rate) disable iff (!i_reset)
        i_res_valid && !i_res_ready |=> i_res_valid && $stable(i_res_data))
        else begin
            fail_res_hold = 1'b1;
            $error("transmit link dropped valid or payload before ready");
        end

endmodule

bind uart_alu_top uart_alu_assertions u_assert (
    .i_rate       (i_rate),
    .i_reset      (i_reset),
    .i_rx         (i_rx),
    .i_tx         (o_tx),
    .i_tick       (tick),
    .i_rx_valid   (rx_valid),
    .i_col_valid  (col_valid),
    .i_col_ready  (col_ready),
    .i_col_cmd    (col_cmd),
    .i_alu_valid  (alu_valid),
    .i_alu_ready  (alu_ready),
    .i_alu_result (alu_result),
    .i_res_valid  (res_valid),
    .i_res_ready  (res_ready),
    .i_res_data   (res_data)
);

// File: verilog/alu_exec.sv
module alu_exec
    import alu_pkg::*;
(
    input  logic        i_rate,
    input  logic        i_reset,
    input  logic        i_valid,
    output logic        o_ready,
    input  alu_cmd_t    i_cmd,
    output logic        o_valid,
    input  logic        i_ready,
    output alu_result_t o_result
);

    alu_result_t result;

    always_comb begin
        case (i_cmd.op)
            OP_ADD:  result = i_cmd.a + i_cmd.b;
            OP_SUB:  result = i_cmd.a - i_cmd.b;   // Wraps mod 256
            OP_AND:  result = i_cmd.a & i_cmd.b;
            OP_OR:   result = i_cmd.a | i_cmd.b;
            OP_XOR:  result = i_cmd.a ^ i_cmd.b;
            OP_NOR:  result = ~(i_cmd.a | i_cmd.b);
            OP_SRA:  result = $signed(i_cmd.a) >>> i_cmd.b;  // Sign fill
            OP_SRL:  result = i_cmd.a >> i_cmd.b;
            default: result = '0;
        endcase
    end

    // Empty or draining this cycle
    assign o_ready = !o_valid || i_ready;

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            o_valid <= 1'b0;
        end else if (i_valid && o_ready) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_rate) begin
        if (i_valid && o_ready) begin
            o_result <= result;
        end
    end

endmodule

// File: verilog/alu_pkg.sv
package alu_pkg;

    // Opcodes, MIPS funct style
    localparam logic [7:0] OP_ADD = 8'h20;
    localparam logic [7:0] OP_SUB = 8'h22;
    localparam logic [7:0] OP_AND = 8'h24;
    localparam logic [7:0] OP_OR  = 8'h25;
    localparam logic [7:0] OP_XOR = 8'h26;
    localparam logic [7:0] OP_NOR = 8'h27;
    localparam logic [7:0] OP_SRA = 8'h03;
    localparam logic [7:0] OP_SRL = 8'h02;

    // Fields in arrival order on the serial line
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] op;
    } alu_cmd_t;

    typedef logic [7:0] alu_result_t;

endpackage

// File: verilog/baud_tick_gen.sv
module baud_tick_gen
    import uart_pkg::*;
(
    input  logic i_rate,
    input  logic i_reset,
    output logic o_tick
);

    logic [$clog2(TICK_DIV)-1:0] div_cnt;

    assign o_tick = (int'(div_cnt) == TICK_DIV - 1);

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            div_cnt <= '0;
        end else if (o_tick) begin
            div_cnt <= '0;              // Wrap
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// File: verilog/cmd_collector.sv
module cmd_collector
    import uart_pkg::*;
    import alu_pkg::*;
(
    input  logic                 i_rate,
    input  logic                 i_reset,
    input  logic                 i_byte_valid,
    input  logic [WORD_BITS-1:0] i_byte,
    output logic                 o_cmd_valid,
    input  logic                 i_cmd_ready,
    output alu_cmd_t             o_cmd
);

    logic [1:0] slot;   // 0 = operand a, 1 = operand b, 2 = opcode

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            slot        <= 2'd0;
            o_cmd_valid <= 1'b0;
        end else if (o_cmd_valid) begin
            if (i_cmd_ready) begin
                o_cmd_valid <= 1'b0;
            end
        end else if (i_byte_valid) begin
            case (slot)
                2'd0: begin
                    slot <= 2'd1;
                end
                2'd1: begin
                    slot <= 2'd2;
                end
                default: begin
                    slot        <= 2'd0;
                    o_cmd_valid <= 1'b1;   // Command complete
                end
            endcase
        end
    end

    // Payload, only written while no command waits
    always_ff @(posedge i_rate) begin
        if (i_byte_valid && !o_cmd_valid) begin
            case (slot)
                2'd0:    o_cmd.a  <= i_byte;
                2'd1:    o_cmd.b  <= i_byte;
                default: o_cmd.op <= i_byte;
            endcase
        end
    end

endmodule

// File: verilog/skid_buffer.sv
module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     i_rate,
    input  logic     i_reset,
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    payload_t   mem [2];
    logic       head;
    logic [1:0] count;
    logic       push;
    logic       pop;
    logic       wr_ptr;

    assign o_ready = (count != 2'd2);     // State only
    assign o_valid = (count != 2'd0);
    assign o_data  = mem[head];

    assign push   = i_valid && o_ready;
    assign pop    = o_valid && i_ready;
    assign wr_ptr = head ^ count[0];      // Slot after the last held entry

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            head  <= 1'b0;
            count <= 2'd0;
        end else begin
            if (pop) begin
                head <= ~head;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_rate) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

// File: verilog/uart_alu_top.sv
module uart_alu_top
    import uart_pkg::*;
    import alu_pkg::*;
(
    input  logic i_rate,
    input  logic i_reset,
    input  logic i_rx,
    output logic o_tx
);

    logic                 tick;
    logic                 rx_valid;
    logic [WORD_BITS-1:0] rx_byte;

    logic                 col_valid;
    logic                 col_ready;
    alu_cmd_t             col_cmd;

    logic                 cmd_valid;
    logic                 cmd_ready;
    alu_cmd_t             cmd;

    logic                 alu_valid;
    logic                 alu_ready;
    alu_result_t          alu_result;

    logic                 res_valid;
    logic                 res_ready;
    alu_result_t          res_data;

    baud_tick_gen u_tick (
        .i_rate  (i_rate),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_rx (
        .i_rate  (i_rate),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rx    (i_rx),
        .o_valid (rx_valid),
        .o_data  (rx_byte)
    );

    cmd_collector u_collector (
        .i_rate       (i_rate),
        .i_reset      (i_reset),
        .i_byte_valid (rx_valid),
        .i_byte       (rx_byte),
        .o_cmd_valid  (col_valid),
        .i_cmd_ready  (col_ready),
        .o_cmd        (col_cmd)
    );

    skid_buffer #(.payload_t(alu_cmd_t)) cmd_buf (
        .i_rate  (i_rate),
        .i_reset (i_reset),
        .i_valid (col_valid),
        .o_ready (col_ready),
        .i_data  (col_cmd),
        .o_valid (cmd_valid),
        .i_ready (cmd_ready),
        .o_data  (cmd)
    );

    alu_exec u_alu (
        .i_rate   (i_rate),
        .i_reset  (i_reset),
        .i_valid  (cmd_valid),
        .o_ready  (cmd_ready),
        .i_cmd    (cmd),
        .o_valid  (alu_valid),
        .i_ready  (alu_ready),
        .o_result (alu_result)
    );

    skid_buffer #(.payload_t(alu_result_t)) res_buf (
        .i_rate  (i_rate),
        .i_reset (i_reset),
        .i_valid (alu_valid),
        .o_ready (alu_ready),
        .i_data  (alu_result),
        .o_valid (res_valid),
        .i_ready (res_ready),
        .o_data  (res_data)
    );

    uart_tx u_tx (
        .i_rate  (i_rate),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_valid (res_valid),
        .o_ready (res_ready),
        .i_data  (res_data),
        .o_tx    (o_tx)
    );

endmodule

// File: verilog/uart_pkg.sv
package uart_pkg;

    localparam int WORD_BITS  = 8;     // Data bits per frame
    localparam int STOP_BITS  = 2;
    localparam int OVERSAMPLE = 16;    // Ticks per bit time

    // 50 MHz / (163 * 16) is about 19200 baud
    localparam int TICK_DIV   = 163;
    localparam int BIT_CYCLES = TICK_DIV * OVERSAMPLE;

    // One-hot receiver states
    typedef enum logic [3:0] {
        RX_IDLE  = 4'b0001,
        RX_START = 4'b0010,
        RX_DATA  = 4'b0100,
        RX_STOP  = 4'b1000
    } rx_state_t;

endpackage

// File: verilog/uart_rx.sv
module uart_rx
    import uart_pkg::*;
(
    input  logic                 i_rate,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_rx,
    output logic                 o_valid,
    output logic [WORD_BITS-1:0] o_data
);

    rx_state_t                     state;
    logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
    logic [$clog2(WORD_BITS)-1:0]  bit_idx;
    logic [$clog2(STOP_BITS)-1:0]  stop_cnt;
    logic [WORD_BITS-1:0]          rx_buf;
    logic                          last_tick;

    assign last_tick = (int'(tick_cnt) == OVERSAMPLE - 1);

    // Byte released at the last stop sample, only if the line is high
    assign o_valid = i_tick && (state == RX_STOP) && last_tick
                     && (int'(stop_cnt) == STOP_BITS - 1) && i_rx;
    assign o_data  = rx_buf;

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            stop_cnt <= '0;
            rx_buf   <= '0;
        end else if (i_tick) begin
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    stop_cnt <= '0;
                    if (!i_rx) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Half a bit in, line must still be low
                    if (int'(tick_cnt) == OVERSAMPLE / 2 - 1) begin
                        tick_cnt <= '0;
                        state    <= i_rx ? RX_IDLE : RX_DATA;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (last_tick) begin
                        tick_cnt <= '0;
                        rx_buf   <= {i_rx, rx_buf[WORD_BITS-1:1]};  // LSB first
                        bit_idx  <= bit_idx + 1'b1;
                        if (int'(bit_idx) == WORD_BITS - 1) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (last_tick) begin
                        tick_cnt <= '0;
                        stop_cnt <= stop_cnt + 1'b1;
                        if (!i_rx || int'(stop_cnt) == STOP_BITS - 1) begin
                            state <= RX_IDLE;      // Done or framing error
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/uart_tx.sv
module uart_tx
    import uart_pkg::*;
    import alu_pkg::*;
(
    input  logic        i_rate,
    input  logic        i_reset,
    input  logic        i_tick,
    input  logic        i_valid,
    output logic        o_ready,
    input  alu_result_t i_data,
    output logic        o_tx
);

    logic [WORD_BITS+STOP_BITS:0]  shreg;     // Stop bits, data, start bit
    logic [3:0]                    bit_cnt;
    logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
    logic                          busy;
    logic                          bit_end;

    assign o_ready = !busy;
    assign bit_end = i_tick && (int'(tick_cnt) == OVERSAMPLE - 1);

    always_ff @(posedge i_rate) begin
        if (!i_reset) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            tick_cnt <= '0;
            o_tx     <= 1'b1;
        end else if (!busy) begin
            if (i_valid) begin
                busy     <= 1'b1;
                bit_cnt  <= '0;
                tick_cnt <= 4'(OVERSAMPLE - 1);   // Start bit on the next tick
            end
        end else if (bit_end) begin
            tick_cnt <= '0;
            if (int'(bit_cnt) == 1 + WORD_BITS + STOP_BITS) begin
                busy <= 1'b0;                     // Last stop bit over
                o_tx <= 1'b1;
            end else begin
                o_tx    <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else if (i_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_rate) begin
        if (!busy && i_valid) begin
            shreg <= {{STOP_BITS{1'b1}}, i_data, 1'b0};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[WORD_BITS+STOP_BITS:1]};
        end
    end

endmodule
